/* cpu_defines.svh */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// Datapath and register address widths
`define XLEN			32
`define REG_ADDR_W		5

// Exception cause codes as written to mcause
`define CAUSE_ILLEGAL_INST	2
`define CAUSE_ECALL_M		11

// PC bits used to index the branch counter table
`define PRED_INDEX_BITS	6

`endif

/* cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

	// RV32I major opcodes taken from bits [6:0] of the instruction word
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_SYSTEM = 7'b1110011
	} opcode_t;

	// Branches reuse SUB, SLT and SLTU to select their comparison
	typedef enum logic [3:0] {
		ALU_ADD    = 4'd0,
		ALU_SUB    = 4'd1,
		ALU_SLL    = 4'd2,
		ALU_SLT    = 4'd3,
		ALU_SLTU   = 4'd4,
		ALU_XOR    = 4'd5,
		ALU_SRL    = 4'd6,
		ALU_SRA    = 4'd7,
		ALU_OR     = 4'd8,
		ALU_AND    = 4'd9,
		ALU_PASS_B = 4'd10
	} alu_op_t;

	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LH   = 4'd2,
		MEM_LW   = 4'd3,
		MEM_LBU  = 4'd4,
		MEM_LHU  = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_t;

	typedef enum logic [1:0] {
		SRC_ALU = 2'd0,
		SRC_MEM = 2'd1,
		SRC_PC4 = 2'd2
	} wb_src_t;

endpackage

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module inst_decoder (
	input  logic [`XLEN-1:0]       ir,
	output logic [`XLEN-1:0]       imm,
	output logic                   rs1_rena,
	output logic [`REG_ADDR_W-1:0] rs1_addr,
	output logic                   rs2_rena,
	output logic [`REG_ADDR_W-1:0] rs2_addr,
	output logic                   rd_wena,
	output logic [`REG_ADDR_W-1:0] rd_addr,
	output logic                   sel_pc,
	output logic                   sel_imm,
	output cpu_pkg::wb_src_t       wb_src,
	output cpu_pkg::alu_op_t       alu_op,
	output cpu_pkg::mem_op_t       mem_op,
	output logic                   jump_ena,
	output logic                   jump_ind,
	output logic                   jump_alw,
	output logic                   env_call,
	output logic                   illegal_inst
);

	import cpu_pkg::*;

	opcode_t    opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       funct7_ok;

	assign opcode   = opcode_t'(ir[6:0]);
	assign funct3   = ir[14:12];
	assign funct7   = ir[31:25];
	assign rs1_addr = ir[19:15];
	assign rs2_addr = ir[24:20];
	assign rd_addr  = ir[11:7];

	// The alternate funct7 only exists for SUB and the arithmetic shift
	assign funct7_ok = (funct7 == 7'b0000000) ||
		(funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));

	function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  return alt ? ALU_SUB : ALU_ADD;
			3'b001:  return ALU_SLL;
			3'b010:  return ALU_SLT;
			3'b011:  return ALU_SLTU;
			3'b100:  return ALU_XOR;
			3'b101:  return alt ? ALU_SRA : ALU_SRL;
			3'b110:  return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	always_comb begin
		case (opcode)
			OPC_LUI, OPC_AUIPC: imm = {ir[31:12], 12'h000};
			OPC_JAL:    imm = {{12{ir[31]}}, ir[19:12], ir[20], ir[30:21], 1'b0};
			OPC_BRANCH: imm = {{20{ir[31]}}, ir[7], ir[30:25], ir[11:8], 1'b0};
			OPC_STORE:  imm = {{21{ir[31]}}, ir[30:25], ir[11:7]};
			default:    imm = {{21{ir[31]}}, ir[30:20]};
		endcase
	end

	always_comb begin
		rs1_rena     = 1'b0;
		rs2_rena     = 1'b0;
		rd_wena      = 1'b0;
		sel_pc       = 1'b0;
		sel_imm      = 1'b0;
		wb_src       = SRC_ALU;
		alu_op       = ALU_ADD;
		mem_op       = MEM_NONE;
		jump_ena     = 1'b0;
		jump_ind     = 1'b0;
		jump_alw     = 1'b0;
		env_call     = 1'b0;
		illegal_inst = 1'b0;

		case (opcode)
			OPC_LUI: begin
				rd_wena = 1'b1;
				sel_imm = 1'b1;
				alu_op  = ALU_PASS_B;
			end
			OPC_AUIPC: begin
				rd_wena = 1'b1;
				sel_pc  = 1'b1;
				sel_imm = 1'b1;
			end
			// The ALU forms the target while rd receives pc + 4
			OPC_JAL: begin
				rd_wena  = 1'b1;
				sel_pc   = 1'b1;
				sel_imm  = 1'b1;
				wb_src   = SRC_PC4;
				jump_ena = 1'b1;
				jump_alw = 1'b1;
			end
			OPC_JALR: begin
				rs1_rena     = 1'b1;
				rd_wena      = 1'b1;
				sel_imm      = 1'b1;
				wb_src       = SRC_PC4;
				jump_ena     = 1'b1;
				jump_ind     = 1'b1;
				jump_alw     = 1'b1;
				illegal_inst = (funct3 != 3'b000);
			end
			OPC_BRANCH: begin
				rs1_rena = 1'b1;
				rs2_rena = 1'b1;
				jump_ena = 1'b1;
				case (funct3[2:1])
					2'b00:   alu_op = ALU_SUB;
					2'b10:   alu_op = ALU_SLT;
					2'b11:   alu_op = ALU_SLTU;
					default: illegal_inst = 1'b1;
				endcase
			end
			OPC_LOAD: begin
				rs1_rena = 1'b1;
				rd_wena  = 1'b1;
				sel_imm  = 1'b1;
				wb_src   = SRC_MEM;
				case (funct3)
					3'b000:  mem_op = MEM_LB;
					3'b001:  mem_op = MEM_LH;
					3'b010:  mem_op = MEM_LW;
					3'b100:  mem_op = MEM_LBU;
					3'b101:  mem_op = MEM_LHU;
					default: illegal_inst = 1'b1;
				endcase
			end
			OPC_STORE: begin
				rs1_rena = 1'b1;
				rs2_rena = 1'b1;
				sel_imm  = 1'b1;
				case (funct3)
					3'b000:  mem_op = MEM_SB;
					3'b001:  mem_op = MEM_SH;
					3'b010:  mem_op = MEM_SW;
					default: illegal_inst = 1'b1;
				endcase
			end
			OPC_OP_IMM: begin
				rs1_rena = 1'b1;
				rd_wena  = 1'b1;
				sel_imm  = 1'b1;
				alu_op   = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
				// Only shifts carry a funct7 field in the immediate
				if (funct3[1:0] == 2'b01)
					illegal_inst = !funct7_ok;
			end
			OPC_OP: begin
				rs1_rena     = 1'b1;
				rs2_rena     = 1'b1;
				rd_wena      = 1'b1;
				alu_op       = arith_op(funct3, funct7[5]);
				illegal_inst = !funct7_ok;
			end
			OPC_SYSTEM: begin
				if (ir == 32'h00000073)
					env_call = 1'b1;
				else
					illegal_inst = 1'b1;
			end
			default: illegal_inst = 1'b1;
		endcase

		if (illegal_inst) begin
			rs1_rena = 1'b0;
			rs2_rena = 1'b0;
			rd_wena  = 1'b0;
			mem_op   = MEM_NONE;
			jump_ena = 1'b0;
			jump_ind = 1'b0;
			jump_alw = 1'b0;
		end
	end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rd_wena,
	input  logic [`REG_ADDR_W-1:0] rd_addr,
	input  logic [`XLEN-1:0]       rd_data,
	input  logic [`REG_ADDR_W-1:0] rs1_addr,
	output logic [`XLEN-1:0]       rs1_data,
	input  logic [`REG_ADDR_W-1:0] rs2_addr,
	output logic [`XLEN-1:0]       rs2_data
);

	// x0 has no storage behind it
	logic [`XLEN-1:0] regs [1:(1 << `REG_ADDR_W) - 1];

	always_ff @(posedge clk) begin
		if (rd_wena && rd_addr != '0)
			regs[rd_addr] <= rd_data;
	end

	// A write in flight is returned directly so decode sees it this cycle
	assign rs1_data = (rs1_addr == '0) ? '0 :
		(rd_wena && rd_addr == rs1_addr) ? rd_data : regs[rs1_addr];

	assign rs2_data = (rs2_addr == '0) ? '0 :
		(rd_wena && rd_addr == rs2_addr) ? rd_data : regs[rs2_addr];

endmodule

`default_nettype wire

/* bypass_logic.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module bypass_logic (
	input  logic                   rs1_rena,
	input  logic [`REG_ADDR_W-1:0] rs1_addr,
	input  logic [`XLEN-1:0]       rs1_data,
	input  logic                   rs2_rena,
	input  logic [`REG_ADDR_W-1:0] rs2_addr,
	input  logic [`XLEN-1:0]       rs2_data,
	input  logic                   rd_wena_ex,
	input  logic [`REG_ADDR_W-1:0] rd_addr_ex,
	input  logic [`XLEN-1:0]       rd_data_ex,
	input  cpu_pkg::wb_src_t       wb_src_ex,
	input  logic                   rd_wena_mem,
	input  logic [`REG_ADDR_W-1:0] rd_addr_mem,
	input  logic [`XLEN-1:0]       rd_data_mem,
	output logic [`XLEN-1:0]       rs1_bypassed,
	output logic [`XLEN-1:0]       rs2_bypassed
);

	import cpu_pkg::*;

	logic ex_fwd;
	logic mem_fwd;

	// A load in EX has no data yet, so only MEM can supply it later
	assign ex_fwd  = rd_wena_ex && (rd_addr_ex != '0) && (wb_src_ex != SRC_MEM);
	assign mem_fwd = rd_wena_mem && (rd_addr_mem != '0);

	// EX holds the younger result and takes priority over MEM
	assign rs1_bypassed = !rs1_rena ? rs1_data :
		(ex_fwd && rd_addr_ex == rs1_addr) ? rd_data_ex :
		(mem_fwd && rd_addr_mem == rs1_addr) ? rd_data_mem : rs1_data;

	assign rs2_bypassed = !rs2_rena ? rs2_data :
		(ex_fwd && rd_addr_ex == rs2_addr) ? rd_data_ex :
		(mem_fwd && rd_addr_mem == rs2_addr) ? rd_data_mem : rs2_data;

endmodule

`default_nettype wire

/* branch_predictor.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module branch_predictor #(
	parameter int index_bits = `PRED_INDEX_BITS
) (
	input  logic             clk,
	input  logic             reset,
	input  logic [`XLEN-1:0] pc,
	input  logic [`XLEN-1:0] imm,
	input  logic             jump_ena,
	input  logic             jump_alw,
	input  logic             jump_ind,
	input  logic [`XLEN-1:0] pc_ex,
	input  logic             jump_ena_ex,
	input  logic             jump_alw_ex,
	input  logic             jump_taken_ex,
	output logic             jump_pred,
	output logic [`XLEN-1:0] jump_addr
);

	localparam int entries = 2 ** index_bits;

	logic [1:0]            counters [entries];
	logic [index_bits-1:0] pred_index;
	logic [index_bits-1:0] upd_index;

	// Instructions are word aligned so the two low PC bits are skipped
	assign pred_index = pc[index_bits+1:2];
	assign upd_index  = pc_ex[index_bits+1:2];

	// JAL is always taken, JALR has a register target and is never predicted
	assign jump_pred = jump_ena && !jump_ind && (jump_alw || counters[pred_index][1]);
	assign jump_addr = pc + imm;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			for (int i = 0; i < entries; i++)
				counters[i] <= 2'b01;
		end else if (jump_ena_ex && !jump_alw_ex) begin
			if (jump_taken_ex && counters[upd_index] != 2'b11)
				counters[upd_index] <= counters[upd_index] + 2'd1;
			else if (!jump_taken_ex && counters[upd_index] != 2'b00)
				counters[upd_index] <= counters[upd_index] - 2'd1;
		end
	end

endmodule

`default_nettype wire

/* id_stage.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module id_stage (
	input  logic                   clk,
	input  logic                   reset,

	input  logic                   valid_in,
	output logic                   ready_out,
	input  logic                   flush_in,
	output logic                   flush_out,
	output logic                   valid_out,
	input  logic                   ready_in,

	input  logic [`XLEN-1:0]       pc_if,
	input  logic [`XLEN-1:0]       ir_if,
	input  logic                   exc_pend_if,
	input  logic [`XLEN-1:0]       exc_cause_if,
	output logic                   jump_pred_if,
	output logic [`XLEN-1:0]       jump_addr_if,

	output logic [`XLEN-1:0]       pc_id,
	output logic [`XLEN-1:0]       ir_id,
	output logic [`XLEN-1:0]       imm_id,
	output logic                   rs1_rena_id,
	output logic [`REG_ADDR_W-1:0] rs1_addr_id,
	output logic [`XLEN-1:0]       rs1_data_id,
	output logic                   rs2_rena_id,
	output logic [`REG_ADDR_W-1:0] rs2_addr_id,
	output logic [`XLEN-1:0]       rs2_data_id,
	output logic                   rd_wena_id,
	output logic [`REG_ADDR_W-1:0] rd_addr_id,
	output logic                   sel_pc_id,
	output logic                   sel_imm_id,
	output cpu_pkg::wb_src_t       wb_src_id,
	output cpu_pkg::alu_op_t       alu_op_id,
	output cpu_pkg::mem_op_t       mem_op_id,
	output logic                   jump_ena_id,
	output logic                   jump_ind_id,
	output logic                   jump_alw_id,
	output logic                   jump_pred_id,
	output logic                   exc_pend_id,
	output logic [`XLEN-1:0]       exc_cause_id,

	input  logic                   rd_wena_ex,
	input  logic [`REG_ADDR_W-1:0] rd_addr_ex,
	input  logic [`XLEN-1:0]       rd_data_ex,
	input  cpu_pkg::wb_src_t       wb_src_ex,
	input  logic                   rd_wena_mem,
	input  logic [`REG_ADDR_W-1:0] rd_addr_mem,
	input  logic [`XLEN-1:0]       rd_data_mem,
	input  logic                   rd_wena_wb,
	input  logic [`REG_ADDR_W-1:0] rd_addr_wb,
	input  logic [`XLEN-1:0]       rd_data_wb,

	input  logic [`XLEN-1:0]       pc_ex,
	input  logic                   jump_ena_ex,
	input  logic                   jump_alw_ex,
	input  logic                   jump_taken_ex
);

	import cpu_pkg::*;

	logic [`XLEN-1:0]       imm;
	logic                   rs1_rena;
	logic [`REG_ADDR_W-1:0] rs1_addr;
	logic [`XLEN-1:0]       rs1_data;
	logic                   rs2_rena;
	logic [`REG_ADDR_W-1:0] rs2_addr;
	logic [`XLEN-1:0]       rs2_data;
	logic                   rd_wena;
	logic [`REG_ADDR_W-1:0] rd_addr;
	logic                   sel_pc;
	logic                   sel_imm;
	wb_src_t                wb_src;
	alu_op_t                alu_op;
	mem_op_t                mem_op;
	logic                   jump_ena;
	logic                   jump_ind;
	logic                   jump_alw;
	logic                   env_call;
	logic                   illegal_inst;
	logic [`XLEN-1:0]       rs1_bypassed;
	logic [`XLEN-1:0]       rs2_bypassed;
	logic                   exc_pend;
	logic [`XLEN-1:0]       exc_cause;
	logic                   accept;
	logic                   clear;

	// A pending exception holds off fetch until the pipeline flushes
	assign ready_out = ready_in && !exc_pend_id;
	assign flush_out = flush_in;
	assign accept    = valid_in && ready_out && !flush_in;
	assign clear     = flush_in || (valid_out && ready_in && !accept);

	// Fetch faults are oldest, then illegal encodings, then ECALL
	assign exc_pend  = exc_pend_if || illegal_inst || env_call;
	assign exc_cause = exc_pend_if ? exc_cause_if :
		illegal_inst ? `XLEN'(`CAUSE_ILLEGAL_INST) :
		env_call ? `XLEN'(`CAUSE_ECALL_M) : '0;

	always_ff @(posedge clk, posedge reset) begin
		if (reset) begin
			valid_out    <= 1'b0;
			rs1_rena_id  <= 1'b0;
			rs2_rena_id  <= 1'b0;
			rd_wena_id   <= 1'b0;
			mem_op_id    <= MEM_NONE;
			jump_ena_id  <= 1'b0;
			jump_ind_id  <= 1'b0;
			jump_alw_id  <= 1'b0;
			jump_pred_id <= 1'b0;
			exc_pend_id  <= 1'b0;
		end else if (accept || clear) begin
			valid_out    <= accept;
			rs1_rena_id  <= accept && rs1_rena;
			rs2_rena_id  <= accept && rs2_rena;
			rd_wena_id   <= accept && rd_wena;
			mem_op_id    <= accept ? mem_op : MEM_NONE;
			jump_ena_id  <= accept && jump_ena;
			jump_ind_id  <= accept && jump_ind;
			jump_alw_id  <= accept && jump_alw;
			jump_pred_id <= accept && jump_pred_if;
			exc_pend_id  <= accept && exc_pend;
		end
	end

	always_ff @(posedge clk) begin
		if (accept || clear) begin
			pc_id        <= accept ? pc_if : '0;
			ir_id        <= accept ? ir_if : '0;
			imm_id       <= accept ? imm : '0;
			rs1_addr_id  <= accept ? rs1_addr : '0;
			rs1_data_id  <= accept ? rs1_data : '0;
			rs2_addr_id  <= accept ? rs2_addr : '0;
			rs2_data_id  <= accept ? rs2_data : '0;
			rd_addr_id   <= accept ? rd_addr : '0;
			sel_pc_id    <= accept && sel_pc;
			sel_imm_id   <= accept && sel_imm;
			wb_src_id    <= accept ? wb_src : SRC_ALU;
			alu_op_id    <= accept ? alu_op : ALU_ADD;
			exc_cause_id <= accept ? exc_cause : '0;
		end else begin
			// Held operands pick up results that retire while EX is stalled
			rs1_data_id  <= rs1_bypassed;
			rs2_data_id  <= rs2_bypassed;
		end
	end

	inst_decoder i_inst_decoder (
		.ir (ir_if),
		.*
	);

	reg_file i_reg_file (
		.rd_wena (rd_wena_wb),
		.rd_addr (rd_addr_wb),
		.rd_data (rd_data_wb),
		.*
	);

	bypass_logic i_bypass_logic (
		.rs1_rena (rs1_rena_id),
		.rs1_addr (rs1_addr_id),
		.rs1_data (rs1_data_id),
		.rs2_rena (rs2_rena_id),
		.rs2_addr (rs2_addr_id),
		.rs2_data (rs2_data_id),
		.*
	);

	branch_predictor #(
		.index_bits (`PRED_INDEX_BITS)
	) i_branch_predictor (
		.pc        (pc_if),
		.jump_pred (jump_pred_if),
		.jump_addr (jump_addr_if),
		.*
	);

endmodule

`default_nettype wire

/* tb_clock.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_clock (
	output logic clk
);

	// 20 ns period
	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

endmodule

`default_nettype wire

/* id_stage_checker.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module id_stage_checker (
	input logic                   clk,
	input logic                   reset,
	input logic                   flush_in,
	input logic                   ready_in,
	input logic                   valid_out,
	input logic                   exc_pend_id,
	input logic [`XLEN-1:0]       pc_id,
	input logic [`XLEN-1:0]       ir_id,
	input logic [`XLEN-1:0]       imm_id,
	input logic [`REG_ADDR_W-1:0] rs1_addr_id,
	input logic [`REG_ADDR_W-1:0] rs2_addr_id,
	input logic                   rd_wena_id,
	input cpu_pkg::alu_op_t       alu_op_id,
	input cpu_pkg::mem_op_t       mem_op_id,
	input cpu_pkg::wb_src_t       wb_src_id
);

	// The stage is empty in the cycle after reset or flush
	assert property (@(posedge clk) (reset || flush_in) |=> !valid_out)
		else $error("valid_out high after reset or flush");

	// Nothing new enters behind a pending exception
	assert property (@(posedge clk) disable iff (reset)
		exc_pend_id |=> (!valid_out || (exc_pend_id && $stable(pc_id))))
		else $error("instruction accepted behind a pending exception");

	// Only the operand data may change while execute stalls
	assert property (@(posedge clk) disable iff (reset)
		(valid_out && !ready_in && !flush_in) |=>
		($stable(pc_id) && $stable(ir_id) && $stable(imm_id) &&
		$stable(rs1_addr_id) && $stable(rs2_addr_id) && $stable(rd_wena_id) &&
		$stable(alu_op_id) && $stable(mem_op_id) && $stable(wb_src_id)))
		else $error("registered fields changed under back-pressure");

endmodule

bind id_stage id_stage_checker i_id_stage_checker (.*);

`default_nettype wire

/* id_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none
`include "cpu_defines.svh"

module id_stage_tb;

	import cpu_pkg::*;

	// Rough length of all tests in clock cycles for the watchdog
	localparam int test_cycles = 220;

	logic clk, reset, valid_in, ready_out, flush_in, flush_out, valid_out, ready_in;
	logic [31:0] pc_if, ir_if, exc_cause_if, jump_addr_if;
	logic exc_pend_if, jump_pred_if;
	logic [31:0] pc_id, ir_id, imm_id, rs1_data_id, rs2_data_id, exc_cause_id;
	logic [4:0] rs1_addr_id, rs2_addr_id, rd_addr_id;
	logic rs1_rena_id, rs2_rena_id, rd_wena_id, sel_pc_id, sel_imm_id;
	logic jump_ena_id, jump_ind_id, jump_alw_id, jump_pred_id, exc_pend_id;
	wb_src_t wb_src_id, wb_src_ex;
	alu_op_t alu_op_id;
	mem_op_t mem_op_id;
	logic rd_wena_ex, rd_wena_mem, rd_wena_wb;
	logic [4:0] rd_addr_ex, rd_addr_mem, rd_addr_wb;
	logic [31:0] rd_data_ex, rd_data_mem, rd_data_wb, pc_ex;
	logic jump_ena_ex, jump_alw_ex, jump_taken_ex;

	logic [31:0] lfsr_state = 32'h6e970535;
	logic [31:0] reg_model [0:31];
	logic [31:0] exp_imm;
	logic exp_has_imm, exp_r1, exp_r2, exp_wena;
	alu_op_t exp_alu;
	mem_op_t exp_mem;
	wb_src_t exp_wb;

	alu_op_t arith_table [0:7] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
		ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
	mem_op_t load_table [0:7] = '{MEM_LB, MEM_LH, MEM_LW, MEM_NONE,
		MEM_LBU, MEM_LHU, MEM_NONE, MEM_NONE};
	mem_op_t store_table [0:3] = '{MEM_SB, MEM_SH, MEM_SW, MEM_NONE};

	tb_clock i_tb_clock (.clk(clk));

	id_stage i_id_stage (.*);

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compare_word(input string name, input logic [`XLEN-1:0] got, exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %h expected %h",
				$time, name, got, exp));
	endtask

	task automatic compare_bit(input string name, input logic got, exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
				$time, name, got, exp));
	endtask

	task automatic compare_alu(input string name, input alu_op_t got, exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compare_mem(input string name, input mem_op_t got, exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	task automatic compare_wb(input string name, input wb_src_t got, exp);
		if (got !== exp)
			fail_run($sformatf("mismatch at %0t ns: %s got %s expected %s",
				$time, name, got.name(), exp.name()));
	endtask

	// Galois LFSR stepped once for every bit taken
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'hA3000000 : lfsr_state >> 1;
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	task automatic decode_model(input logic [31:0] ir);
		logic [2:0] f3;
		f3 = ir[14:12];
		exp_alu = ALU_ADD;
		exp_mem = MEM_NONE;
		exp_wb = SRC_ALU;
		exp_r1 = 1'b0;
		exp_r2 = 1'b0;
		exp_wena = 1'b1;
		exp_has_imm = 1'b1;
		exp_imm = {{20{ir[31]}}, ir[31:20]};
		case (ir[6:0])
			7'b0110111: begin
				exp_imm = {ir[31:12], 12'h000};
				exp_alu = ALU_PASS_B;
			end
			7'b0110011: begin
				exp_r1 = 1'b1;
				exp_r2 = 1'b1;
				exp_has_imm = 1'b0;
				exp_alu = (f3 == 3'd0 && ir[30]) ? ALU_SUB :
					(f3 == 3'd5 && ir[30]) ? ALU_SRA : arith_table[f3];
			end
			7'b0010011: begin
				exp_r1 = 1'b1;
				exp_alu = (f3 == 3'd5 && ir[30]) ? ALU_SRA : arith_table[f3];
			end
			7'b0000011: begin
				exp_r1 = 1'b1;
				exp_wb = SRC_MEM;
				exp_mem = load_table[f3];
			end
			default: begin
				// Store
				exp_r1 = 1'b1;
				exp_r2 = 1'b1;
				exp_wena = 1'b0;
				exp_imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
				exp_mem = store_table[f3[1:0]];
			end
		endcase
	endtask

	// Presents one instruction and returns after the accepting edge
	task automatic issue(input logic [31:0] ir, pc, input logic exc,
		input logic [31:0] cause, input logic hold);
		@(posedge clk);
		valid_in <= 1'b1;
		ir_if <= ir;
		pc_if <= pc;
		exc_pend_if <= exc;
		exc_cause_if <= cause;
		@(posedge clk);
		valid_in <= 1'b0;
		exc_pend_if <= 1'b0;
		if (hold)
			ready_in <= 1'b0;
		@(negedge clk);
	endtask

	task automatic check_decode(input logic [31:0] ir, pc);
		decode_model(ir);
		compare_bit("valid_out", valid_out, 1'b1);
		compare_word("pc_id", pc_id, pc);
		compare_word("ir_id", ir_id, ir);
		compare_alu("alu_op_id", alu_op_id, exp_alu);
		compare_mem("mem_op_id", mem_op_id, exp_mem);
		compare_wb("wb_src_id", wb_src_id, exp_wb);
		compare_bit("rs1_rena_id", rs1_rena_id, exp_r1);
		compare_bit("rs2_rena_id", rs2_rena_id, exp_r2);
		compare_bit("rd_wena_id", rd_wena_id, exp_wena);
		compare_bit("sel_pc_id", sel_pc_id, 1'b0);
		compare_bit("sel_imm_id", sel_imm_id, exp_has_imm);
		compare_bit("jump_ena_id", jump_ena_id, 1'b0);
		compare_bit("exc_pend_id", exc_pend_id, 1'b0);
		compare_word("rd_addr_id", rd_addr_id, ir[11:7]);
		if (exp_has_imm)
			compare_word("imm_id", imm_id, exp_imm);
		if (exp_r1) begin
			compare_word("rs1_addr_id", rs1_addr_id, ir[19:15]);
			compare_word("rs1_data_id", rs1_data_id, reg_model[ir[19:15]]);
		end
		if (exp_r2) begin
			compare_word("rs2_addr_id", rs2_addr_id, ir[24:20]);
			compare_word("rs2_data_id", rs2_data_id, reg_model[ir[24:20]]);
		end
	endtask

	task automatic decode_test;
		logic [31:0] ir, pc, imm;
		logic [4:0] rs1, rs2, rd;
		logic [2:0] f3;
		logic [6:0] f7;
		for (int r = 1; r < 32; r++) begin
			@(posedge clk);
			reg_model[r] = rand_bits(32);
			rd_wena_wb <= 1'b1;
			rd_addr_wb <= r;
			rd_data_wb <= reg_model[r];
		end
		@(posedge clk);
		rd_wena_wb <= 1'b0;
		for (int i = 0; i < 15; i++) begin
			rs1 = (i == 0) ? 5'd0 : rand_bits(5);
			rs2 = rand_bits(5);
			rd = rand_bits(5);
			f3 = rand_bits(3);
			imm = rand_bits(12);
			pc = rand_bits(30) << 2;
			f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_bits(1)) ? 7'h20 : 7'h00;
			case (i % 5)
				0: ir = {f7, rs2, rs1, f3, rd, 7'b0110011};
				1: begin
					if (f3[1:0] == 2'b01)
						imm[11:5] = (f3 == 3'd5) ? f7 : 7'h00;
					ir = {imm[11:0], rs1, f3, rd, 7'b0010011};
				end
				2: begin
					if (f3 == 3'd3 || f3 > 3'd5)
						f3 = 3'd2;
					ir = {imm[11:0], rs1, f3, rd, 7'b0000011};
				end
				3: ir = {imm[11:5], rs2, rs1, 1'b0, (f3[1:0] == 2'b11) ? 2'b10 : f3[1:0],
					imm[4:0], 7'b0100011};
				default: ir = (rand_bits(20) << 12) | {rd, 7'b0110111};
			endcase
			issue(ir, pc, 1'b0, '0, 1'b0);
			check_decode(ir, pc);
		end
		// Write-back and decode of the same register in one cycle
		reg_model[9] = rand_bits(32);
		ir = {7'h00, 5'd9, 5'd9, 3'b000, 5'd4, 7'b0110011};
		@(posedge clk);
		rd_wena_wb <= 1'b1;
		rd_addr_wb <= 5'd9;
		rd_data_wb <= reg_model[9];
		valid_in <= 1'b1;
		ir_if <= ir;
		pc_if <= 32'h100;
		@(posedge clk);
		rd_wena_wb <= 1'b0;
		valid_in <= 1'b0;
		@(negedge clk);
		check_decode(ir, 32'h100);
	endtask

	task automatic flush_pulse;
		@(posedge clk);
		flush_in <= 1'b1;
		@(negedge clk);
		compare_bit("flush_out", flush_out, 1'b1);
		@(posedge clk);
		flush_in <= 1'b0;
		ready_in <= 1'b1;
		@(negedge clk);
		compare_bit("flush_out", flush_out, 1'b0);
		compare_bit("valid_out", valid_out, 1'b0);
		compare_bit("exc_pend_id", exc_pend_id, 1'b0);
		compare_word("ir_id", ir_id, '0);
		compare_word("pc_id", pc_id, '0);
	endtask

	task automatic exception_case(input logic [31:0] ir, input logic exc,
		input logic [31:0] cause_in, exp_cause);
		issue(ir, 32'h40, exc, cause_in, 1'b0);
		compare_bit("exc_pend_id", exc_pend_id, 1'b1);
		compare_word("exc_cause_id", exc_cause_id, exp_cause);
		compare_bit("ready_out", ready_out, 1'b0);
		compare_bit("rd_wena_id", rd_wena_id, 1'b0);
		flush_pulse();
		compare_bit("ready_out", ready_out, 1'b1);
	endtask

	function automatic logic [31:0] forward(input logic [31:0] old, input logic [4:0] rs,
		input logic ex_en, input logic [4:0] ex_a, input logic [31:0] dx,
		input wb_src_t ex_src, input logic mem_en, input logic [4:0] mem_a,
		input logic [31:0] dm);
		if (rs != 0 && ex_en && ex_a == rs && ex_src != SRC_MEM)
			return dx;
		if (rs != 0 && mem_en && mem_a == rs)
			return dm;
		return old;
	endfunction

	task automatic bypass_step(input logic ex_en, input logic [4:0] ex_a,
		input wb_src_t ex_src, input logic mem_en, input logic [4:0] mem_a,
		inout logic [31:0] exp1, exp2, input logic [31:0] held_ir);
		logic [31:0] dx, dm;
		dx = rand_bits(32);
		dm = rand_bits(32);
		@(posedge clk);
		rd_wena_ex <= ex_en;
		rd_addr_ex <= ex_a;
		rd_data_ex <= dx;
		wb_src_ex <= ex_src;
		rd_wena_mem <= mem_en;
		rd_addr_mem <= mem_a;
		rd_data_mem <= dm;
		exp1 = forward(exp1, 5'd5, ex_en, ex_a, dx, ex_src, mem_en, mem_a, dm);
		exp2 = forward(exp2, 5'd0, ex_en, ex_a, dx, ex_src, mem_en, mem_a, dm);
		@(posedge clk);
		rd_wena_ex <= 1'b0;
		rd_wena_mem <= 1'b0;
		@(negedge clk);
		compare_word("rs1_data_id", rs1_data_id, exp1);
		compare_word("rs2_data_id", rs2_data_id, exp2);
		compare_word("ir_id", ir_id, held_ir);
		compare_bit("valid_out", valid_out, 1'b1);
		compare_alu("alu_op_id", alu_op_id, ALU_ADD);
	endtask

	task automatic bypass_test;
		logic [31:0] ir, exp1, exp2;
		// add x3, x5, x0 held in ID/EX
		ir = {7'h00, 5'd0, 5'd5, 3'b000, 5'd3, 7'b0110011};
		exp1 = reg_model[5];
		exp2 = '0;
		issue(ir, 32'h200, 1'b0, '0, 1'b1);
		bypass_step(1'b0, 5'd0, SRC_ALU, 1'b1, 5'd5, exp1, exp2, ir);
		bypass_step(1'b1, 5'd5, SRC_ALU, 1'b1, 5'd5, exp1, exp2, ir);
		bypass_step(1'b1, 5'd5, SRC_MEM, 1'b0, 5'd0, exp1, exp2, ir);
		bypass_step(1'b1, 5'd0, SRC_ALU, 1'b1, 5'd0, exp1, exp2, ir);
		bypass_step(1'b0, 5'd5, SRC_ALU, 1'b0, 5'd5, exp1, exp2, ir);
		bypass_step(1'b1, 5'd5, SRC_PC4, 1'b0, 5'd0, exp1, exp2, ir);
		@(posedge clk);
		ready_in <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		compare_bit("valid_out", valid_out, 1'b0);
	endtask

	task automatic predict_check(input logic [31:0] ir, pc, input logic exp_pred,
		input logic [31:0] exp_addr);
		@(posedge clk);
		ir_if <= ir;
		pc_if <= pc;
		@(negedge clk);
		compare_bit("jump_pred_if", jump_pred_if, exp_pred);
		if (exp_pred)
			compare_word("jump_addr_if", jump_addr_if, exp_addr);
	endtask

	// Accepts a JAL or JALR and checks the jump controls that reach execute
	task automatic check_jump_decode(input logic [31:0] ir, pc, input logic exp_ind,
		input logic exp_pred);
		issue(ir, pc, 1'b0, '0, 1'b0);
		compare_bit("valid_out", valid_out, 1'b1);
		compare_bit("jump_ena_id", jump_ena_id, 1'b1);
		compare_bit("jump_alw_id", jump_alw_id, 1'b1);
		compare_bit("jump_ind_id", jump_ind_id, exp_ind);
		compare_bit("jump_pred_id", jump_pred_id, exp_pred);
		compare_bit("sel_pc_id", sel_pc_id, !exp_ind);
		compare_bit("sel_imm_id", sel_imm_id, 1'b1);
		compare_wb("wb_src_id", wb_src_id, SRC_PC4);
	endtask

	task automatic resolve(input logic [31:0] pc, input logic taken);
		@(posedge clk);
		pc_ex <= pc;
		jump_ena_ex <= 1'b1;
		jump_alw_ex <= 1'b0;
		jump_taken_ex <= taken;
		@(posedge clk);
		jump_ena_ex <= 1'b0;
	endtask

	task automatic predictor_test;
		logic [31:0] j, b, imm, pc, ir;
		j = rand_bits(20);
		imm = {{11{j[19]}}, j[19:0], 1'b0};
		pc = rand_bits(30) << 2;
		ir = {imm[20], imm[10:1], imm[11], imm[19:12], 5'd1, 7'b1101111};
		predict_check(ir, pc, 1'b1, pc + imm);
		check_jump_decode(ir, pc, 1'b0, 1'b1);
		ir = (rand_bits(12) << 20) | {5'd2, 3'b000, 5'd1, 7'b1100111};
		predict_check(ir, pc, 1'b0, '0);
		check_jump_decode(ir, pc, 1'b1, 1'b0);
		b = rand_bits(12);
		imm = {{19{b[11]}}, b[11:0], 1'b0};
		pc = rand_bits(30) << 2;
		ir = {imm[12], imm[10:5], 5'd2, 5'd1, 3'b000, imm[4:1], imm[11], 7'b1100011};
		predict_check(ir, pc, 1'b0, '0);
		resolve(pc, 1'b1);
		predict_check(ir, pc, 1'b1, pc + imm);
		resolve(pc, 1'b0);
		resolve(pc, 1'b0);
		predict_check(ir, pc, 1'b0, '0);
	endtask

	task automatic flush_test;
		logic [31:0] ir;
		ir = {12'h123, 5'd1, 3'b000, 5'd2, 7'b0010011};
		issue(ir, 32'h300, 1'b0, '0, 1'b1);
		flush_pulse();
		compare_bit("rd_wena_id", rd_wena_id, 1'b0);
		issue(ir, 32'h304, 1'b0, '0, 1'b0);
		compare_bit("valid_out", valid_out, 1'b1);
		@(negedge clk);
		compare_bit("valid_out", valid_out, 1'b0);
		compare_word("ir_id", ir_id, '0);
	endtask

	initial begin
		#(test_cycles * 20 + 2000);
		fail_run("watchdog expired before the tests finished");
	end

	initial begin
		reg_model[0] = '0;
		reset <= 1'b1;
		{valid_in, flush_in, exc_pend_if, rd_wena_ex, rd_wena_mem, rd_wena_wb} <= '0;
		{jump_ena_ex, jump_alw_ex, jump_taken_ex} <= '0;
		ready_in <= 1'b1;
		{pc_if, ir_if, exc_cause_if, pc_ex} <= '0;
		{rd_addr_ex, rd_addr_mem, rd_addr_wb} <= '0;
		{rd_data_ex, rd_data_mem, rd_data_wb} <= '0;
		wb_src_ex <= SRC_ALU;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		decode_test();
		exception_case(32'hffffffff, 1'b0, '0, `CAUSE_ILLEGAL_INST);
		exception_case(32'h00000073, 1'b0, '0, `CAUSE_ECALL_M);
		exception_case(32'hffffffff, 1'b1, 32'd1, 32'd1);
		exception_case(32'h00000073, 1'b1, 32'd5, 32'd5);
		bypass_test();
		predictor_test();
		flush_test();
		$display("test passed");
		$finish;
	end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
cpu_pkg.sv
inst_decoder.sv
reg_file.sv
bypass_logic.sv
branch_predictor.sv
id_stage.sv
tb_clock.sv
id_stage_checker.sv
id_stage_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the ID stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module id_stage_tb -f list.f -o id_stage_sim
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/id_stage_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "test passed" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
